// ==== src.f ====
+incdir+sim
src/csr_pkg.sv
src/trap_pkg.sv
src/csr_access_decode.sv
src/csr_reg_bank.sv
src/trap_unit.sv
src/csr_top.sv
sim/csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module csr_tb -f src.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vcsr_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "TEST RESULT: PASS"; then
  exit 0
fi
exit 1

// ==== sim/csr_model.svh ====
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// Addresses that an M-mode write may change
function automatic logic write_allowed(input priv_e priv, input logic [11:0] addr);
  logic hit;
  case (addr)
    12'h300, 12'h304, 12'h305, 12'h340, 12'h341, 12'h343, 12'h344,
    12'h701, 12'h702, 12'hB00, 12'hB02, 12'hB80, 12'hB82: hit = 1'b1;
    default: hit = 1'b0;
  endcase
  return hit && (priv == PRIV_M);
endfunction

// Plain read/write registers, no counters
function automatic logic plain_reg(input logic [11:0] addr);
  case (addr)
    12'h300, 12'h304, 12'h305, 12'h340, 12'h341, 12'h343, 12'h344: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// Machine ID block, zero for anything else
function automatic logic [31:0] id_value(input logic [11:0] addr);
  case (addr)
    12'hF11: return MVENDOR_ID;
    12'hF12: return MARCH_ID;
    12'hF13: return MIMP_ID;
    12'hF14: return MHART_ID;
    default: return 32'h0;
  endcase
endfunction

// Lowest cause code wins
function automatic logic [31:0] expected_cause(input exc_t flags);
  if (flags.instr_misaligned) begin
    return 32'd0;
  end else if (flags.instr_fault) begin
    return 32'd1;
  end else if (flags.illegal) begin
    return 32'd2;
  end
  return 32'd11;
endfunction

// Address for fetch faults, opcode for illegal, nothing for ecall
function automatic logic [31:0] expected_tval(input exc_t flags, input trap_info_t info);
  if (flags.instr_misaligned || flags.instr_fault) begin
    return info.faulting_address;
  end else if (flags.illegal) begin
    return info.faulting_instruction;
  end
  return 32'h0;
endfunction

// Direct mode only, mode bits dropped
function automatic logic [31:0] handler_addr(input logic [31:0] mtvec);
  return mtvec & 32'hFFFF_FFFC;
endfunction

`endif

// ==== sim/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb;
  import csr_pkg::*;
  import trap_pkg::*;

  `include "csr_model.svh"

  localparam logic [31:0] SEED = 32'd57074;
  localparam int N_RETIRE = 20;
  localparam int N_TRAPS  = 16;
  // Reset, rw, privilege, counters, minstret, traps, ID reads, tail
  localparam int TEST_LEN = 8 + 16 + 40 + 16 + (N_RETIRE + 2) + 3 * N_TRAPS + 8 + 2;
  localparam int TIMEOUT_CYCLES = 2 * TEST_LEN;

  logic            clk;
  logic            reset;
  csr_bus_t        csr_bus;
  logic            instruction_retired;
  exc_t            exc;
  trap_info_t      trap_info;
  logic [XLEN-1:0] rdata;
  logic            error;
  logic            serve_trap;
  logic [XLEN-1:0] trap_handler_addr;
  csr_view_t       csr_view;

  // Expected state, updated at each falling edge
  logic [31:0] shadow [0:4095];
  logic [11:0] rw_list [0:6];
  logic [11:0] bad_list [0:4];
  logic        exp_rd_valid;
  logic [31:0] exp_rdata;
  logic        err_pending;
  logic        trap_pending;
  logic [31:0] exp_epc;
  logic [31:0] exp_tval;
  logic [31:0] rng_state;
  int          error_count;
  int          check_count;
  int          cycle_count;

  csr_top UUT (
    .clk                   (clk),
    .reset                 (reset),
    .csr_bus_i             (csr_bus),
    .instruction_retired_i (instruction_retired),
    .exc_i                 (exc),
    .trap_info_i           (trap_info),
    .rdata_o               (rdata),
    .error_o               (error),
    .serve_trap_o          (serve_trap),
    .trap_handler_addr_o   (trap_handler_addr),
    .csr_view_o            (csr_view)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Software view of a read, counters excluded
  function automatic logic [31:0] model_read(input logic [11:0] addr);
    if (plain_reg(addr) || addr == 12'h342) begin
      return shadow[addr];
    end
    return id_value(addr);
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    check_count++;
    assert (got === exp)
      else begin
        error_count++;
        $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
  endtask

  // One bus cycle, inputs driven just after the rising edge
  task automatic bus_cycle(input logic rd, input logic wr, input priv_e priv,
                           input logic [11:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    #1;
    csr_bus.rd          = rd;
    csr_bus.wr          = wr;
    csr_bus.priv        = priv;
    csr_bus.addr        = addr;
    csr_bus.wdata       = wdata;
    exc                 = '0;
    instruction_retired = 1'b0;
    exp_rd_valid        = 1'b0;
  endtask

  // Counter read with a value from the caller
  task automatic read_expect(input logic [11:0] addr, input logic [31:0] value);
    bus_cycle(1'b1, 1'b0, PRIV_M, addr, 32'h0);
    exp_rd_valid = 1'b1;
    exp_rdata    = value;
  endtask

  task automatic write_readback();
    for (int n = 0; n < 7; n++) begin
      bus_cycle(1'b0, 1'b1, PRIV_M, rw_list[n], next_rand());
      bus_cycle(1'b1, 1'b0, PRIV_M, rw_list[n], 32'h0);
    end
    // mcause only changes on a trap
    bus_cycle(1'b0, 1'b1, PRIV_M, 12'h342, next_rand());
    bus_cycle(1'b1, 1'b0, PRIV_M, 12'h342, 32'h0);
  endtask

  task automatic privilege_rejects();
    for (int n = 0; n < 7; n++) begin
      for (int p = 0; p < 2; p++) begin
        bus_cycle(1'b0, 1'b1, (p == 0) ? PRIV_U : PRIV_S, rw_list[n], next_rand());
        bus_cycle(1'b1, 1'b0, PRIV_M, rw_list[n], 32'h0);
      end
    end
    // Read-only and unmapped targets
    for (int n = 0; n < 5; n++) begin
      bus_cycle(1'b0, 1'b1, PRIV_M, bad_list[n], next_rand());
      bus_cycle(1'b1, 1'b0, PRIV_M, bad_list[n], 32'h0);
    end
    bus_cycle(1'b0, 1'b1, PRIV_M, 12'hC01, next_rand());
    bus_cycle(1'b0, 1'b0, PRIV_M, 12'h000, 32'h0);
  endtask

  task automatic counter_load(input logic [11:0] wr_lo, input logic [11:0] wr_hi,
                              input logic [11:0] rd_lo, input logic [11:0] rd_hi);
    logic [31:0] hi;
    logic [63:0] base;
    logic [63:0] cur;
    hi   = next_rand();
    base = {hi, 32'hFFFF_FFFD};
    bus_cycle(1'b0, 1'b1, PRIV_M, wr_hi, hi);
    bus_cycle(1'b0, 1'b1, PRIV_M, wr_lo, base[31:0]);
    // Carry into the high half shows on the fourth read
    for (int k = 0; k < 6; k++) begin
      cur = base + 64'(k);
      if (k % 2 == 0) begin
        read_expect(rd_lo, cur[31:0]);
      end else begin
        read_expect(rd_hi, cur[63:32]);
      end
    end
  endtask

  task automatic retire_count();
    logic [31:0] start;
    logic [31:0] pulses;
    logic [31:0] r;
    start  = next_rand();
    pulses = 32'h0;
    // A load beats a retire pulse in the same cycle
    bus_cycle(1'b0, 1'b1, PRIV_M, 12'hB02, start);
    instruction_retired = 1'b1;
    for (int n = 0; n < N_RETIRE; n++) begin
      bus_cycle(1'b0, 1'b0, PRIV_M, 12'h000, 32'h0);
      r = next_rand();
      instruction_retired = r[0];
      pulses = pulses + {31'b0, r[0]};
    end
    read_expect(12'hB02, start + pulses);
  endtask

  task automatic trap_capture();
    logic [31:0] r;
    for (int n = 0; n < N_TRAPS; n++) begin
      // New handler base, random mode bits
      bus_cycle(1'b0, 1'b1, PRIV_M, 12'h305, next_rand());
      r = next_rand();
      // Software write that the trap must override
      bus_cycle(1'b0, 1'b1, PRIV_M, r[4] ? 12'h343 : 12'h341, next_rand());
      if (r[3:0] == 4'b0000) begin
        exc = 4'b0001;
      end else begin
        exc = r[3:0];
      end
      trap_info.pc                   = next_rand();
      trap_info.faulting_address     = next_rand();
      trap_info.faulting_instruction = next_rand();
      bus_cycle(1'b1, 1'b0, PRIV_M, 12'h342, 32'h0);
    end
  endtask

  task automatic id_reads();
    for (int n = 0; n < 4; n++) begin
      bus_cycle(1'b1, 1'b0, PRIV_M, 12'hF11 + 12'(n), 32'h0);
    end
    bus_cycle(1'b1, 1'b0, PRIV_M, 12'h123, 32'h0);
    bus_cycle(1'b1, 1'b0, PRIV_M, 12'h7FF, 32'h0);
    // Write window of mtime is not readable
    bus_cycle(1'b1, 1'b0, PRIV_M, 12'h701, 32'h0);
    bus_cycle(1'b0, 1'b0, PRIV_M, 12'h300, 32'h0);
  endtask

  // Compare outputs mid-cycle, then advance the model
  always @(negedge clk) begin
    if (!reset) begin
      if (!csr_bus.rd) begin
        check_value(rdata, 32'h0, "read data with rd low");
      end else if (exp_rd_valid) begin
        check_value(rdata, exp_rdata, "counter read");
      end else begin
        check_value(rdata, model_read(csr_bus.addr), "register read");
      end
      check_value({31'b0, error}, {31'b0, err_pending}, "error pulse");
      check_value({31'b0, serve_trap}, {31'b0, exc != 4'b0000}, "serve_trap");
      if (exc != 4'b0000) begin
        check_value(trap_handler_addr, handler_addr(shadow[12'h305]), "handler address");
      end
      // Pipeline view follows the registers
      check_value(csr_view.mstatus, shadow[12'h300], "mstatus view");
      check_value(csr_view.mie, shadow[12'h304], "mie view");
      check_value(csr_view.mtvec, shadow[12'h305], "mtvec view");
      check_value(csr_view.mip, shadow[12'h344], "mip view");
      if (trap_pending) begin
        check_value(csr_view.mepc, exp_epc, "mepc after trap");
        check_value(csr_view.mtval, exp_tval, "mtval after trap");
      end
      err_pending  = csr_bus.wr && !write_allowed(csr_bus.priv, csr_bus.addr);
      trap_pending = (exc != 4'b0000);
      if (csr_bus.wr && write_allowed(csr_bus.priv, csr_bus.addr) && plain_reg(csr_bus.addr)) begin
        shadow[csr_bus.addr] = csr_bus.wdata;
      end
      // Capture overrides the write above
      if (trap_pending) begin
        exp_epc = trap_info.pc;
        exp_tval = expected_tval(exc, trap_info);
        shadow[12'h341] = exp_epc;
        shadow[12'h342] = expected_cause(exc);
        shadow[12'h343] = exp_tval;
      end
    end
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    reset               = 1'b1;
    csr_bus             = '0;
    instruction_retired = 1'b0;
    exc                 = '0;
    trap_info           = '0;
    exp_rd_valid        = 1'b0;
    exp_rdata           = 32'h0;
    err_pending         = 1'b0;
    trap_pending        = 1'b0;
    exp_epc             = 32'h0;
    exp_tval            = 32'h0;
    rng_state           = SEED;
    error_count         = 0;
    check_count         = 0;
    for (int a = 0; a < 4096; a++) begin
      shadow[a] = 32'h0;
    end
    shadow[12'h300] = INITIAL_MSTATUS;
    shadow[12'h305] = INITIAL_MTVEC;
    rw_list  = '{12'h300, 12'h304, 12'h305, 12'h340, 12'h341, 12'h343, 12'h344};
    bad_list = '{12'hF11, 12'hF14, 12'h342, 12'h123, 12'h7FF};
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    write_readback();
    privilege_rejects();
    counter_load(12'hB00, 12'hB80, 12'hB00, 12'hB80);
    counter_load(12'h701, 12'h702, 12'hC01, 12'hC81);
    retire_count();
    trap_capture();
    id_reads();
    bus_cycle(1'b0, 1'b0, PRIV_M, 12'h000, 32'h0);
    @(negedge clk);
    #1;
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/csr_top.sv ====
`timescale 1ns/1ps

module csr_top (
  input  logic                      clk,
  input  logic                      reset,
  input  csr_pkg::csr_bus_t         csr_bus_i,
  input  logic                      instruction_retired_i,
  input  trap_pkg::exc_t            exc_i,
  input  trap_pkg::trap_info_t      trap_info_i,
  output logic [csr_pkg::XLEN-1:0]  rdata_o,
  output logic                      error_o,
  output logic                      serve_trap_o,
  output logic [csr_pkg::XLEN-1:0]  trap_handler_addr_o,
  output csr_pkg::csr_view_t        csr_view_o
);
  import csr_pkg::*;
  import trap_pkg::*;

  csr_req_t        csr_req;
  trap_capture_t   capture;
  logic [XLEN-1:0] mtvec;

  // Address decode and privilege check
  csr_access_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .csr_bus_i (csr_bus_i),
    .csr_req_o (csr_req),
    .error_o   (error_o)
  );

  // Register file and counters
  csr_reg_bank u_bank (
    .clk                   (clk),
    .reset                 (reset),
    .csr_req_i             (csr_req),
    .capture_i             (capture),
    .instruction_retired_i (instruction_retired_i),
    .rdata_o               (rdata_o),
    .mtvec_o               (mtvec),
    .csr_view_o            (csr_view_o)
  );

  // Exception priority and handler address
  trap_unit u_trap (
    .exc_i               (exc_i),
    .trap_info_i         (trap_info_i),
    .mtvec_i             (mtvec),
    .capture_o           (capture),
    .serve_trap_o        (serve_trap_o),
    .trap_handler_addr_o (trap_handler_addr_o)
  );

endmodule

// ==== src/trap_unit.sv ====
`timescale 1ns/1ps

module trap_unit (
  input  trap_pkg::exc_t            exc_i,
  input  trap_pkg::trap_info_t      trap_info_i,
  input  logic [csr_pkg::XLEN-1:0]  mtvec_i,
  output trap_pkg::trap_capture_t   capture_o,
  output logic                      serve_trap_o,
  output logic [csr_pkg::XLEN-1:0]  trap_handler_addr_o
);
  import csr_pkg::*;
  import trap_pkg::*;

  cause_e          cause;
  logic [XLEN-1:0] tval;

  // Fixed priority, lowest cause code first
  always_comb begin
    cause = CAUSE_INSTR_MISALIGNED;
    tval  = '0;
    if (exc_i.instr_misaligned) begin
      cause = CAUSE_INSTR_MISALIGNED;
      tval  = trap_info_i.faulting_address;
    end else if (exc_i.instr_fault) begin
      cause = CAUSE_INSTR_FAULT;
      tval  = trap_info_i.faulting_address;
    end else if (exc_i.illegal) begin
      // Illegal instruction reports the opcode word
      cause = CAUSE_ILLEGAL;
      tval  = trap_info_i.faulting_instruction;
    end else if (exc_i.ecall_m) begin
      // No faulting address for ecall
      cause = CAUSE_ECALL_M;
      tval  = '0;
    end
  end

  // Any flag raises the trap
  assign serve_trap_o = |exc_i;

  assign capture_o.take  = serve_trap_o;
  assign capture_o.cause = cause;
  assign capture_o.epc   = trap_info_i.pc;
  assign capture_o.tval  = tval;

  // Exceptions only, so vectored offsets never apply
  assign trap_handler_addr_o = {mtvec_i[XLEN-1:2], 2'b00};

endmodule

// ==== src/csr_reg_bank.sv ====
`timescale 1ns/1ps

module csr_reg_bank (
  input  logic                       clk,
  input  logic                       reset,
  input  csr_pkg::csr_req_t          csr_req_i,
  input  trap_pkg::trap_capture_t    capture_i,
  input  logic                       instruction_retired_i,
  output logic [csr_pkg::XLEN-1:0]   rdata_o,
  output logic [csr_pkg::XLEN-1:0]   mtvec_o,
  output csr_pkg::csr_view_t         csr_view_o
);
  import csr_pkg::*;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] mip_q;
  logic [63:0]     mcycle_q;
  logic [63:0]     mtime_q;
  logic [63:0]     minstret_q;

  // Per-half counter write strobes
  logic wr_mcycle_lo;
  logic wr_mcycle_hi;
  logic wr_mtime_lo;
  logic wr_mtime_hi;
  logic wr_minstret_lo;
  logic wr_minstret_hi;

  assign wr_mcycle_lo   = csr_req_i.wr && (csr_req_i.sel == SEL_MCYCLE_LO);
  assign wr_mcycle_hi   = csr_req_i.wr && (csr_req_i.sel == SEL_MCYCLE_HI);
  assign wr_mtime_lo    = csr_req_i.wr && (csr_req_i.sel == SEL_MTIME_LO);
  assign wr_mtime_hi    = csr_req_i.wr && (csr_req_i.sel == SEL_MTIME_HI);
  assign wr_minstret_lo = csr_req_i.wr && (csr_req_i.sel == SEL_MINSTRET_LO);
  assign wr_minstret_hi = csr_req_i.wr && (csr_req_i.sel == SEL_MINSTRET_HI);

  // Next counter value, a written half replaces the increment
  function automatic logic [63:0] counter_next(input logic [63:0]     cur,
                                               input logic            inc,
                                               input logic            wr_lo,
                                               input logic            wr_hi,
                                               input logic [XLEN-1:0] wdata);
    logic [63:0] nxt;
    nxt = cur;
    if (wr_lo) begin
      nxt[31:0] = wdata;
    end else if (wr_hi) begin
      nxt[63:32] = wdata;
    end else if (inc) begin
      nxt = cur + 64'd1;
    end
    return nxt;
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mstatus_q  <= INITIAL_MSTATUS;
      mie_q      <= '0;
      mtvec_q    <= INITIAL_MTVEC;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mip_q      <= '0;
      mcycle_q   <= '0;
      mtime_q    <= '0;
      minstret_q <= '0;
    end else begin
      // Plain software registers
      if (csr_req_i.wr) begin
        case (csr_req_i.sel)
          SEL_MSTATUS:  mstatus_q  <= csr_req_i.wdata;
          SEL_MIE:      mie_q      <= csr_req_i.wdata;
          SEL_MTVEC:    mtvec_q    <= csr_req_i.wdata;
          SEL_MSCRATCH: mscratch_q <= csr_req_i.wdata;
          SEL_MIP:      mip_q      <= csr_req_i.wdata;
          default: ;
        endcase
      end
      // Trap capture wins over a same-cycle software write
      if (capture_i.take) begin
        mepc_q   <= capture_i.epc;
        mcause_q <= capture_i.cause;
        mtval_q  <= capture_i.tval;
      end else if (csr_req_i.wr && (csr_req_i.sel == SEL_MEPC)) begin
        mepc_q <= csr_req_i.wdata;
      end else if (csr_req_i.wr && (csr_req_i.sel == SEL_MTVAL)) begin
        mtval_q <= csr_req_i.wdata;
      end
      // Free-running timers, minstret on retire pulses
      mcycle_q   <= counter_next(mcycle_q, 1'b1, wr_mcycle_lo, wr_mcycle_hi,
                                 csr_req_i.wdata);
      mtime_q    <= counter_next(mtime_q, 1'b1, wr_mtime_lo, wr_mtime_hi,
                                 csr_req_i.wdata);
      minstret_q <= counter_next(minstret_q, instruction_retired_i, wr_minstret_lo,
                                 wr_minstret_hi, csr_req_i.wdata);
    end
  end

  // Read mux, zero when idle or unmapped
  always_comb begin
    rdata_o = '0;
    if (csr_req_i.rd) begin
      case (csr_req_i.sel)
        SEL_MSTATUS:     rdata_o = mstatus_q;
        SEL_MIE:         rdata_o = mie_q;
        SEL_MTVEC:       rdata_o = mtvec_q;
        SEL_MSCRATCH:    rdata_o = mscratch_q;
        SEL_MEPC:        rdata_o = mepc_q;
        SEL_MCAUSE:      rdata_o = mcause_q;
        SEL_MTVAL:       rdata_o = mtval_q;
        SEL_MIP:         rdata_o = mip_q;
        SEL_MCYCLE_LO:   rdata_o = mcycle_q[31:0];
        SEL_MCYCLE_HI:   rdata_o = mcycle_q[63:32];
        SEL_MINSTRET_LO: rdata_o = minstret_q[31:0];
        SEL_MINSTRET_HI: rdata_o = minstret_q[63:32];
        SEL_MTIME_LO:    rdata_o = mtime_q[31:0];
        SEL_MTIME_HI:    rdata_o = mtime_q[63:32];
        SEL_MVENDORID:   rdata_o = MVENDOR_ID;
        SEL_MARCHID:     rdata_o = MARCH_ID;
        SEL_MIMPID:      rdata_o = MIMP_ID;
        SEL_MHARTID:     rdata_o = MHART_ID;
        default:         rdata_o = '0;
      endcase
    end
  end

  assign mtvec_o            = mtvec_q;
  assign csr_view_o.mstatus = mstatus_q;
  assign csr_view_o.mepc    = mepc_q;
  assign csr_view_o.mtval   = mtval_q;
  assign csr_view_o.mtvec   = mtvec_q;
  assign csr_view_o.mie     = mie_q;
  assign csr_view_o.mip     = mip_q;

  // Cause of a taken trap lands in mcause one edge later
  assert property (@(posedge clk) disable iff (reset)
                   capture_i.take |=> mcause_q == $past(capture_i.cause))
    else $error("mcause does not hold the captured trap cause");

endmodule

// ==== src/csr_access_decode.sv ====
`timescale 1ns/1ps

module csr_access_decode (
  input  logic              clk,
  input  logic              reset,
  input  csr_pkg::csr_bus_t csr_bus_i,
  output csr_pkg::csr_req_t csr_req_o,
  output logic              error_o
);
  import csr_pkg::*;

  csr_sel_e addr_sel;
  logic     readable;
  logic     writable;
  logic     wr_ok;
  logic     error_q;

  // Address to register, with access rights per address
  always_comb begin
    addr_sel = SEL_NONE;
    readable = 1'b1;
    writable = 1'b1;
    case (csr_bus_i.addr)
      CSR_MSTATUS:   addr_sel = SEL_MSTATUS;
      CSR_MIE:       addr_sel = SEL_MIE;
      CSR_MTVEC:     addr_sel = SEL_MTVEC;
      CSR_MSCRATCH:  addr_sel = SEL_MSCRATCH;
      CSR_MEPC:      addr_sel = SEL_MEPC;
      CSR_MTVAL:     addr_sel = SEL_MTVAL;
      CSR_MIP:       addr_sel = SEL_MIP;
      CSR_MCYCLE:    addr_sel = SEL_MCYCLE_LO;
      CSR_MCYCLEH:   addr_sel = SEL_MCYCLE_HI;
      CSR_MINSTRET:  addr_sel = SEL_MINSTRET_LO;
      CSR_MINSTRETH: addr_sel = SEL_MINSTRET_HI;
      // mcause is only loaded by traps
      CSR_MCAUSE: begin
        addr_sel = SEL_MCAUSE;
        writable = 1'b0;
      end
      // Write-only window onto mtime
      CSR_MTIMEW_LO: begin
        addr_sel = SEL_MTIME_LO;
        readable = 1'b0;
      end
      CSR_MTIMEW_HI: begin
        addr_sel = SEL_MTIME_HI;
        readable = 1'b0;
      end
      // Read-only views of mtime
      CSR_MTIME: begin
        addr_sel = SEL_MTIME_LO;
        writable = 1'b0;
      end
      CSR_MTIMEH: begin
        addr_sel = SEL_MTIME_HI;
        writable = 1'b0;
      end
      // Machine ID block, read only
      CSR_MVENDORID: begin
        addr_sel = SEL_MVENDORID;
        writable = 1'b0;
      end
      CSR_MARCHID: begin
        addr_sel = SEL_MARCHID;
        writable = 1'b0;
      end
      CSR_MIMPID: begin
        addr_sel = SEL_MIMPID;
        writable = 1'b0;
      end
      CSR_MHARTID: begin
        addr_sel = SEL_MHARTID;
        writable = 1'b0;
      end
      default: begin
        addr_sel = SEL_NONE;
        writable = 1'b0;
      end
    endcase
  end

  // Only M-mode may write, and only writable addresses
  assign wr_ok = csr_bus_i.wr && (csr_bus_i.priv == PRIV_M) && writable;

  assign csr_req_o.rd    = csr_bus_i.rd;
  assign csr_req_o.wr    = wr_ok;
  assign csr_req_o.wdata = csr_bus_i.wdata;
  // Rejected write selects nothing
  assign csr_req_o.sel   = csr_bus_i.wr ? (wr_ok ? addr_sel : SEL_NONE)
                                        : (readable ? addr_sel : SEL_NONE);

  // One-cycle error pulse after a rejected write
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      error_q <= 1'b0;
    end else begin
      error_q <= csr_bus_i.wr && !wr_ok;
    end
  end

  assign error_o = error_q;

  // Error only ever reports a write of the previous cycle
  assert property (@(posedge clk) disable iff (reset) error_o |-> $past(csr_bus_i.wr))
    else $error("error_o without a write in the previous cycle");

endmodule

// ==== src/trap_pkg.sv ====
package trap_pkg;

  // Synchronous exception codes written to mcause
  typedef enum logic [csr_pkg::XLEN-1:0] {
    CAUSE_INSTR_MISALIGNED = 32'd0,
    CAUSE_INSTR_FAULT      = 32'd1,
    CAUSE_ILLEGAL          = 32'd2,
    CAUSE_ECALL_M          = 32'd11
  } cause_e;

  // Exception flags, highest priority first
  typedef struct packed {
    logic instr_misaligned;
    logic instr_fault;
    logic illegal;
    logic ecall_m;
  } exc_t;

  // Context of the faulting instruction
  typedef struct packed {
    logic [csr_pkg::XLEN-1:0] pc;
    logic [csr_pkg::XLEN-1:0] faulting_address;
    logic [csr_pkg::XLEN-1:0] faulting_instruction;
  } trap_info_t;

  // Values loaded into mepc, mcause and mtval on a trap
  typedef struct packed {
    logic                     take;
    cause_e                   cause;
    logic [csr_pkg::XLEN-1:0] epc;
    logic [csr_pkg::XLEN-1:0] tval;
  } trap_capture_t;

  // mtvec[1:0] mode field
  typedef enum logic [1:0] {
    MODE_DIRECT   = 2'b00,
    MODE_VECTORED = 2'b01
  } mtvec_mode_e;

endpackage

// ==== src/csr_pkg.sv ====
package csr_pkg;

  // Data and address widths
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  // Privilege levels as encoded on the bus
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  // Implemented CSR addresses
  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MIE       = 12'h304,
    CSR_MTVEC     = 12'h305,
    CSR_MSCRATCH  = 12'h340,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MTVAL     = 12'h343,
    CSR_MIP       = 12'h344,
    // mtime write window, read back through 0xC01/0xC81
    CSR_MTIMEW_LO = 12'h701,
    CSR_MTIMEW_HI = 12'h702,
    CSR_MCYCLE    = 12'hB00,
    CSR_MINSTRET  = 12'hB02,
    CSR_MCYCLEH   = 12'hB80,
    CSR_MINSTRETH = 12'hB82,
    CSR_MTIME     = 12'hC01,
    CSR_MTIMEH    = 12'hC81,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12,
    CSR_MIMPID    = 12'hF13,
    CSR_MHARTID   = 12'hF14
  } csr_addr_e;

  // Register select, one value per readable word
  typedef enum logic [4:0] {
    SEL_NONE, SEL_MSTATUS, SEL_MIE, SEL_MTVEC, SEL_MSCRATCH, SEL_MEPC,
    SEL_MCAUSE, SEL_MTVAL, SEL_MIP, SEL_MCYCLE_LO, SEL_MCYCLE_HI,
    SEL_MINSTRET_LO, SEL_MINSTRET_HI, SEL_MTIME_LO, SEL_MTIME_HI,
    SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID
  } csr_sel_e;

  // Raw software access from the core
  typedef struct packed {
    logic                  rd;
    logic                  wr;
    priv_e                 priv;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       wdata;
  } csr_bus_t;

  // Decoded access, wr already qualified by the privilege check
  typedef struct packed {
    logic            rd;
    logic            wr;
    csr_sel_e        sel;
    logic [XLEN-1:0] wdata;
  } csr_req_t;

  // Direct CSR outputs for the pipeline
  typedef struct packed {
    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mip;
  } csr_view_t;

  // Machine ID values and reset values
  localparam logic [XLEN-1:0] MVENDOR_ID      = 32'h0000_0000;
  localparam logic [XLEN-1:0] MARCH_ID        = 32'h0000_0000;
  localparam logic [XLEN-1:0] MIMP_ID         = 32'h0000_0001;
  localparam logic [XLEN-1:0] MHART_ID        = 32'h0000_0000;
  localparam logic [XLEN-1:0] INITIAL_MTVEC   = 32'h0001_0000;
  localparam logic [XLEN-1:0] INITIAL_MSTATUS = 32'h0000_0080;

endpackage
